/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_clock_top
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := ALL CHECKS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/tb_clock_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_top;

	localparam int SW_MODE       = 0;
	localparam int SW_POS        = 1;
	localparam int SW_INC        = 2;
	localparam int SW_AEN        = 3;
	localparam int HOLD_CYCLES   = 3 * clock_pkg::SW_TICK_DIV;
	localparam int SEC_CYCLES    = clock_pkg::SEC_TICK_DIV;
	localparam int SCAN_LIMIT    = 4 * clock_pkg::NUM_DIGITS * clock_pkg::SCAN_TICK_DIV;
	localparam int ALARM_TIMEOUT = 90 * clock_pkg::SEC_TICK_DIV;
	localparam int COUNT_SECS    = 70;	// crosses a minute carry
	localparam int WATCHDOG_NS   = 2000000;

	logic					clk;
	logic					rst_n;
	logic					i_sw_mode;
	logic					i_sw_pos;
	logic					i_sw_inc;
	logic					i_sw_alarm_en;
	logic [clock_pkg::SEG_W-1:0]		o_seg;
	logic [clock_pkg::NUM_DIGITS-1:0]	o_seg_enb;
	logic					o_alarm;
	int					checks;
	int					errors;

	clock_top u_dut (
		.o_seg		(o_seg),
		.o_seg_enb	(o_seg_enb),
		.o_alarm	(o_alarm),
		.i_sw_mode	(i_sw_mode),
		.i_sw_pos	(i_sw_pos),
		.i_sw_inc	(i_sw_inc),
		.i_sw_alarm_en	(i_sw_alarm_en),
		.clk		(clk),
		.rst_n		(rst_n)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// --------------------------------------------------
	// reference model, times packed as {hr, min, sec}
	// --------------------------------------------------
	function automatic logic [17:0] expect_time(input logic [17:0] start, input int count,
			input int field, input bit carry);
		int h;
		int m;
		int s;
		int total;
		h = int'(start[17:12]);
		m = int'(start[11:6]);
		s = int'(start[5:0]);
		if (carry) begin	// seconds of day
			total = (h * 3600 + m * 60 + s + count) % 86400;
			h = total / 3600;
			m = (total / 60) % 60;
			s = total % 60;
		end else if (field == 0)
			s = (s + count) % 60;
		else if (field == 1)
			m = (m + count) % 60;
		else
			h = (h + count) % 24;
		return {6'(h), 6'(m), 6'(s)};
	endfunction

	function automatic int seg_to_digit(input logic [clock_pkg::SEG_W-1:0] pattern);
		for (int d = 0; d < 10; d++) begin
			if (clock_pkg::SEG_DIGITS[d] == pattern)
				return d;
		end
		return -1;	// blank or garbage
	endfunction

	task automatic report_time(input string name, input logic [17:0] exp, input logic [17:0] act);
		errors++;
		$display("CHECK FAILED %s: expected %02d:%02d:%02d actual %02d:%02d:%02d", name,
			exp[17:12], exp[11:6], exp[5:0], act[17:12], act[11:6], act[5:0]);
	endtask

	task automatic check_time(input string name, input logic [17:0] exp, input logic [17:0] act);
		checks++;
		if (act !== exp)
			report_time(name, exp, act);
	endtask

	// one second of slack for scan lag
	task automatic check_time_near(input string name, input logic [17:0] exp,
			input logic [17:0] act);
		checks++;
		if (act !== exp && act !== expect_time(exp, 1, 0, 1'b1))
			report_time(name, exp, act);
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s: expected %0b actual %0b", name, exp, act);
		end
	endtask

	// --------------------------------------------------
	// switch stimulus and display reader
	// --------------------------------------------------
	task automatic drive_switch(input int which, input logic level);
		@(posedge clk);
		#1;
		case (which)
			SW_MODE: i_sw_mode = level;
			SW_POS:  i_sw_pos = level;
			SW_INC:  i_sw_inc = level;
			default: i_sw_alarm_en = level;
		endcase
	endtask

	task automatic press_switch(input int which, input int times);
		for (int n = 0; n < times; n++) begin
			drive_switch(which, 1'b1);
			repeat (HOLD_CYCLES) @(posedge clk);
			drive_switch(which, 1'b0);
			repeat (HOLD_CYCLES) @(posedge clk);
		end
	endtask

	task automatic read_scan(output logic [17:0] t, output bit ok);
		int digit [clock_pkg::NUM_DIGITS];
		int got;
		int cycles;
		int d;
		got = 0;
		cycles = 0;
		for (int i = 0; i < clock_pkg::NUM_DIGITS; i++)
			digit[i] = -1;
		while (got < clock_pkg::NUM_DIGITS && cycles < SCAN_LIMIT) begin
			@(negedge clk);
			cycles++;
			for (int i = 0; i < clock_pkg::NUM_DIGITS; i++) begin
				if (!o_seg_enb[i] && digit[i] < 0) begin
					d = seg_to_digit(o_seg);
					if (d >= 0) begin
						digit[i] = d;
						got++;
					end
				end
			end
		end
		ok = (got == clock_pkg::NUM_DIGITS);
		t = {6'(digit[5] * 10 + digit[4]), 6'(digit[3] * 10 + digit[2]),
			6'(digit[1] * 10 + digit[0])};
	endtask

	// two matching scans in a row
	task automatic read_display(output logic [17:0] t);
		logic [17:0]	prev;
		logic [17:0]	cur;
		bit		ok;
		bit		settled;
		int		tries;
		prev = '1;
		settled = 1'b0;
		for (tries = 0; tries < 8 && !settled; tries++) begin
			read_scan(cur, ok);
			if (ok && cur == prev)
				settled = 1'b1;
			prev = ok ? cur : '1;
		end
		if (!settled) begin
			errors++;
			$display("display reading never settled, the digit scan looks stuck or garbled");
		end
		t = prev;
	endtask

	task automatic set_field(input int field, input int target, inout logic [17:0] cur);
		int now;
		int span;
		int n;
		now = (field == 2) ? int'(cur[17:12]) : (field == 1) ? int'(cur[11:6]) : int'(cur[5:0]);
		span = (field == 2) ? 24 : 60;
		n = (target - now + span) % span;
		press_switch(SW_INC, n);
		cur = expect_time(cur, n, field, 1'b0);
	endtask

	task automatic wait_alarm_rise(output bit rose);
		int n;
		rose = 1'b0;
		for (n = 0; n < ALARM_TIMEOUT && !rose; n++) begin
			@(negedge clk);
			if (o_alarm)
				rose = 1'b1;
		end
	endtask

	always @(negedge clk) begin
		if (rst_n && !$onehot(~o_seg_enb)) begin
			errors++;
			$display("CHECK FAILED seg_enb_one_low: expected one low bit actual %b", o_seg_enb);
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("simulation time limit reached before the test sequence ended");
		$display("checks run: %0d, errors: %0d", checks, errors + 1);
		$display("CHECKS FAILED");
		$finish;
	end

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial begin
		logic [17:0]	shown;
		logic [17:0]	cur;
		logic [17:0]	start;
		logic [17:0]	alarm_t;
		int		n;
		int		k;
		bit		rose;
		bit		wrapped;
		bit		matched;
		void'($urandom(32'hf9dfe603));
		checks = 0;
		errors = 0;
		rst_n = 1'b0;
		i_sw_mode = 1'b0;
		i_sw_pos = 1'b0;
		i_sw_inc = 1'b0;
		i_sw_alarm_en = 1'b0;
		repeat (3) @(posedge clk);
		#1 rst_n = 1'b1;

		@(negedge clk);
		check_bit("reset_alarm", 1'b0, o_alarm);
		read_display(shown);
		check_time("reset_display", '0, shown);

		repeat (COUNT_SECS * SEC_CYCLES) @(posedge clk);
		read_display(shown);
		check_time_near("clock_count", expect_time('0, COUNT_SECS, 0, 1'b1), shown);

		press_switch(SW_MODE, 1);	// setup
		read_display(cur);
		repeat (3 * SEC_CYCLES) @(posedge clk);
		read_display(shown);
		check_time("setup_freeze", cur, shown);
		for (int f = 0; f < 3; f++) begin	// sec, min, hr
			n = 1 + int'($urandom % 64);
			press_switch(SW_INC, n);
			cur = expect_time(cur, n, f, 1'b0);
			read_display(shown);
			check_time($sformatf("setup_inc_field%0d", f), cur, shown);
			if (f < 2)
				press_switch(SW_POS, 1);
		end

		// 23:59:58, position is on hours here
		set_field(2, 23, cur);
		press_switch(SW_POS, 1);
		set_field(0, 58, cur);
		press_switch(SW_POS, 1);
		set_field(1, 59, cur);
		read_display(shown);
		check_time("rollover_set", cur, shown);

		start = cur;
		press_switch(SW_MODE, 2);	// through alarm back to clock
		wrapped = 1'b0;
		for (int r = 0; r < 12 && !wrapped; r++) begin
			read_display(shown);
			matched = 1'b0;
			for (k = 0; k <= 8; k++) begin
				if (shown == expect_time(start, k, 0, 1'b1)) begin
					matched = 1'b1;
					if (k >= 2)
						wrapped = 1'b1;
				end
			end
			checks++;
			if (!matched)
				report_time("rollover_run", expect_time(start, 2, 0, 1'b1), shown);
		end
		if (!wrapped) begin
			errors++;
			$display("time never rolled over from 23:59:59 to 00:00:00");
		end

		press_switch(SW_MODE, 2);	// alarm mode, position on minutes
		read_display(shown);
		check_time("alarm_show_reset", '0, shown);
		press_switch(SW_INC, 1);
		alarm_t = expect_time('0, 1, 1, 1'b0);
		read_display(shown);
		check_time("alarm_show_set", alarm_t, shown);
		press_switch(SW_MODE, 1);
		press_switch(SW_AEN, 1);
		read_display(shown);
		checks++;
		if (shown >= alarm_t) begin
			errors++;
			$display("time is already at or past the alarm time before the alarm could fire");
		end
		@(negedge clk);
		check_bit("alarm_early", 1'b0, o_alarm);

		wait_alarm_rise(rose);
		if (!rose) begin
			errors++;
			$display("timeout waiting for o_alarm to rise");
		end
		read_display(shown);
		check_time_near("alarm_time", alarm_t, shown);
		repeat (3 * SEC_CYCLES) @(posedge clk);
		@(negedge clk);
		check_bit("alarm_hold", 1'b1, o_alarm);
		press_switch(SW_AEN, 1);
		@(negedge clk);
		check_bit("alarm_off", 1'b0, o_alarm);

		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
verilog/clock_pkg.sv
verilog/tick_gen.sv
verilog/panel_ctrl.sv
verilog/timekeeper.sv
verilog/seg_pair_encoder.sv
verilog/scan_driver.sv
verilog/clock_top.sv
verif/tb_clock_top.sv

/* verilog/clock_pkg.sv */
`default_nettype none

package clock_pkg;

	// --------------------------------------------------
	// widths and counts
	// --------------------------------------------------
	localparam int FIELD_W    = 6;
	localparam int DIGIT_W    = 4;
	localparam int SEG_W      = 7;	// a..g, msb first, active high
	localparam int NUM_FIELDS = 3;	// hr, min, sec
	localparam int NUM_DIGITS = 6;

	// last value before wrap
	localparam logic [FIELD_W-1:0] SEC_MAX = 6'd59;
	localparam logic [FIELD_W-1:0] MIN_MAX = 6'd59;
	localparam logic [FIELD_W-1:0] HR_MAX  = 6'd23;

	// clk cycles per tick, short for sim
	localparam int SEC_TICK_DIV  = 64;
	localparam int SCAN_TICK_DIV = 4;
	localparam int SW_TICK_DIV   = 8;

	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_e;

	typedef enum logic [1:0] {
		POS_SEC = 2'd0,
		POS_MIN = 2'd1,
		POS_HR  = 2'd2
	} pos_e;

	// --------------------------------------------------
	// seven segment patterns
	// --------------------------------------------------
	localparam logic [0:9][SEG_W-1:0] SEG_DIGITS = '{
		7'b111_1110, 7'b011_0000, 7'b110_1101, 7'b111_1001, 7'b011_0011,
		7'b101_1011, 7'b101_1111, 7'b111_0000, 7'b111_1111, 7'b111_0011
	};
	localparam logic [SEG_W-1:0] SEG_BLANK = 7'b000_0000;

endpackage

`default_nettype wire

/* verilog/clock_top.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_top (
	output logic [clock_pkg::SEG_W-1:0]		o_seg,
	output logic [clock_pkg::NUM_DIGITS-1:0]	o_seg_enb,
	output logic					o_alarm,
	input  logic					i_sw_mode,
	input  logic					i_sw_pos,
	input  logic					i_sw_inc,
	input  logic					i_sw_alarm_en,
	input  logic					clk,
	input  logic					rst_n
);

	logic			sec_tick;
	logic			scan_tick;
	logic			sw_tick;
	clock_pkg::mode_e	mode;
	clock_pkg::pos_e	pos;
	logic			alarm_en;
	logic			inc_time;
	logic			inc_alarm;

	logic [clock_pkg::NUM_FIELDS-1:0][clock_pkg::FIELD_W-1:0]	field_show;	// 2 hr .. 0 sec
	logic [clock_pkg::NUM_DIGITS-1:0][clock_pkg::SEG_W-1:0]	digit_seg;

	tick_gen u_tick_gen (
		.o_sec_tick	(sec_tick),
		.o_scan_tick	(scan_tick),
		.o_sw_tick	(sw_tick),
		.clk		(clk),
		.rst_n		(rst_n)
	);

	panel_ctrl u_panel_ctrl (
		.o_mode		(mode),
		.o_pos		(pos),
		.o_alarm_en	(alarm_en),
		.o_inc_time	(inc_time),
		.o_inc_alarm	(inc_alarm),
		.i_sw_mode	(i_sw_mode),
		.i_sw_pos	(i_sw_pos),
		.i_sw_inc	(i_sw_inc),
		.i_sw_alarm_en	(i_sw_alarm_en),
		.i_sw_tick	(sw_tick),
		.clk		(clk),
		.rst_n		(rst_n)
	);

	timekeeper u_timekeeper (
		.o_hr_show	(field_show[2]),
		.o_min_show	(field_show[1]),
		.o_sec_show	(field_show[0]),
		.o_alarm	(o_alarm),
		.i_sec_tick	(sec_tick),
		.i_mode		(mode),
		.i_pos		(pos),
		.i_inc_time	(inc_time),
		.i_inc_alarm	(inc_alarm),
		.i_alarm_en	(alarm_en),
		.clk		(clk),
		.rst_n		(rst_n)
	);

	// field g feeds digits 2g+1 (tens) and 2g (ones), hours on top
	generate
		for (genvar g = 0; g < clock_pkg::NUM_FIELDS; g++) begin : g_enc
			seg_pair_encoder u_seg_pair_encoder (
				.o_seg_tens	(digit_seg[2*g+1]),
				.o_seg_ones	(digit_seg[2*g]),
				.i_field	(field_show[g])
			);
		end
	endgenerate

	scan_driver u_scan_driver (
		.o_seg		(o_seg),
		.o_seg_enb	(o_seg_enb),
		.i_scan_tick	(scan_tick),
		.i_digit_seg	(digit_seg),
		.clk		(clk),
		.rst_n		(rst_n)
	);

endmodule

`default_nettype wire

/* verilog/panel_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module panel_ctrl (
	output clock_pkg::mode_e	o_mode,
	output clock_pkg::pos_e		o_pos,
	output logic			o_alarm_en,
	output logic			o_inc_time,
	output logic			o_inc_alarm,
	input  logic			i_sw_mode,
	input  logic			i_sw_pos,
	input  logic			i_sw_inc,
	input  logic			i_sw_alarm_en,
	input  logic			i_sw_tick,
	input  logic			clk,
	input  logic			rst_n
);

	logic [3:0]	sw_now;		// {mode, pos, inc, alarm_en}
	logic [3:0]	sw_prev;
	logic [3:0]	sw_rise;
	logic		sample_d;	// fresh sample in sw_now
	logic		rise_mode;
	logic		rise_pos;
	logic		rise_inc;
	logic		rise_alarm_en;

	// --------------------------------------------------
	// switch sampling and edge detect
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sw_now   <= '0;
			sw_prev  <= '0;
			sample_d <= 1'b0;
		end else begin
			sample_d <= i_sw_tick;
			if (i_sw_tick) begin
				sw_now  <= {i_sw_mode, i_sw_pos, i_sw_inc, i_sw_alarm_en};
				sw_prev <= sw_now;
			end
		end
	end

	assign sw_rise = {4{sample_d}} & sw_now & ~sw_prev;
	assign {rise_mode, rise_pos, rise_inc, rise_alarm_en} = sw_rise;

	// --------------------------------------------------
	// mode, position, alarm enable
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode     <= clock_pkg::MODE_CLOCK;
			o_pos      <= clock_pkg::POS_SEC;
			o_alarm_en <= 1'b0;
		end else begin
			if (rise_mode) begin
				case (o_mode)
					clock_pkg::MODE_CLOCK:	o_mode <= clock_pkg::MODE_SETUP;
					clock_pkg::MODE_SETUP:	o_mode <= clock_pkg::MODE_ALARM;
					default:		o_mode <= clock_pkg::MODE_CLOCK;
				endcase
			end
			if (rise_pos) begin
				case (o_pos)
					clock_pkg::POS_SEC:	o_pos <= clock_pkg::POS_MIN;
					clock_pkg::POS_MIN:	o_pos <= clock_pkg::POS_HR;
					default:		o_pos <= clock_pkg::POS_SEC;
				endcase
			end
			if (rise_alarm_en)
				o_alarm_en <= ~o_alarm_en;
		end
	end

	// increment goes to time or alarm depending on mode
	assign o_inc_time  = rise_inc && (o_mode == clock_pkg::MODE_SETUP);
	assign o_inc_alarm = rise_inc && (o_mode == clock_pkg::MODE_ALARM);

	// one press, one single-cycle step on one target
	a_inc_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		(o_inc_time || o_inc_alarm) |->
		!(o_inc_time && o_inc_alarm) ##1 !(o_inc_time || o_inc_alarm));

endmodule

`default_nettype wire

/* verilog/scan_driver.sv */
`timescale 1ns/1ps
`default_nettype none

module scan_driver (
	output logic [clock_pkg::SEG_W-1:0]					o_seg,
	output logic [clock_pkg::NUM_DIGITS-1:0]				o_seg_enb,
	input  logic								i_scan_tick,
	input  logic [clock_pkg::NUM_DIGITS-1:0][clock_pkg::SEG_W-1:0]	i_digit_seg,
	input  logic								clk,
	input  logic								rst_n
);

	logic [$clog2(clock_pkg::NUM_DIGITS)-1:0]	digit_idx;
	logic [clock_pkg::NUM_DIGITS-1:0]		enb_cur;	// active low select

	always_comb begin
		enb_cur = '1;
		enb_cur[digit_idx] = 1'b0;
	end

	// --------------------------------------------------
	// digit scan, enable and pattern move together
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			digit_idx <= '0;
			o_seg_enb <= {{(clock_pkg::NUM_DIGITS-1){1'b1}}, 1'b0};
			o_seg     <= clock_pkg::SEG_BLANK;
		end else if (i_scan_tick) begin
			o_seg_enb <= enb_cur;
			o_seg     <= i_digit_seg[digit_idx];
			if (int'(digit_idx) == clock_pkg::NUM_DIGITS - 1)
				digit_idx <= '0;
			else
				digit_idx <= digit_idx + 1'b1;
		end
	end

	// one digit lit at a time
	a_enb_one_low: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(~o_seg_enb));

endmodule

`default_nettype wire

/* verilog/seg_pair_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

module seg_pair_encoder (
	output logic [clock_pkg::SEG_W-1:0]	o_seg_tens,
	output logic [clock_pkg::SEG_W-1:0]	o_seg_ones,
	input  logic [clock_pkg::FIELD_W-1:0]	i_field
);

	logic [clock_pkg::FIELD_W-1:0]	tens_full;
	logic [clock_pkg::FIELD_W-1:0]	ones_full;
	logic [clock_pkg::DIGIT_W-1:0]	tens;
	logic [clock_pkg::DIGIT_W-1:0]	ones;

	// digit to segments, blank for anything not decimal
	function automatic logic [clock_pkg::SEG_W-1:0] digit_seg(
		input logic [clock_pkg::DIGIT_W-1:0] digit
	);
		if (digit > 4'd9)
			return clock_pkg::SEG_BLANK;
		return clock_pkg::SEG_DIGITS[digit];
	endfunction

	// --------------------------------------------------
	// split into two decimal digits
	// --------------------------------------------------
	assign tens_full = i_field / 6'd10;
	assign ones_full = i_field % 6'd10;
	assign tens      = tens_full[clock_pkg::DIGIT_W-1:0];
	assign ones      = ones_full[clock_pkg::DIGIT_W-1:0];

	assign o_seg_tens = digit_seg(tens);
	assign o_seg_ones = digit_seg(ones);

endmodule

`default_nettype wire

/* verilog/tick_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tick_gen (
	output logic	o_sec_tick,
	output logic	o_scan_tick,
	output logic	o_sw_tick,
	input  logic	clk,
	input  logic	rst_n
);

	logic [$clog2(clock_pkg::SEC_TICK_DIV)-1:0]	sec_cnt;
	logic [$clog2(clock_pkg::SCAN_TICK_DIV)-1:0]	scan_cnt;
	logic [$clog2(clock_pkg::SW_TICK_DIV)-1:0]	sw_cnt;
	logic [2:0]					ticks;

	// free running dividers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sec_cnt  <= '0;
			scan_cnt <= '0;
			sw_cnt   <= '0;
		end else begin
			sec_cnt  <= o_sec_tick ? '0 : sec_cnt + 1'b1;
			scan_cnt <= o_scan_tick ? '0 : scan_cnt + 1'b1;
			sw_cnt   <= o_sw_tick ? '0 : sw_cnt + 1'b1;
		end
	end

	// strobe on the last cycle of each period
	assign o_sec_tick  = (int'(sec_cnt) == clock_pkg::SEC_TICK_DIV - 1);
	assign o_scan_tick = (int'(scan_cnt) == clock_pkg::SCAN_TICK_DIV - 1);
	assign o_sw_tick   = (int'(sw_cnt) == clock_pkg::SW_TICK_DIV - 1);

	assign ticks = {o_sec_tick, o_scan_tick, o_sw_tick};

	a_tick_single: assert property (@(posedge clk) disable iff (!rst_n)
		(ticks & $past(ticks)) == 3'b000);

endmodule

`default_nettype wire

/* verilog/timekeeper.sv */
`timescale 1ns/1ps
`default_nettype none

module timekeeper (
	output logic [clock_pkg::FIELD_W-1:0]	o_hr_show,
	output logic [clock_pkg::FIELD_W-1:0]	o_min_show,
	output logic [clock_pkg::FIELD_W-1:0]	o_sec_show,
	output logic				o_alarm,
	input  logic				i_sec_tick,
	input  clock_pkg::mode_e		i_mode,
	input  clock_pkg::pos_e			i_pos,
	input  logic				i_inc_time,
	input  logic				i_inc_alarm,
	input  logic				i_alarm_en,
	input  logic				clk,
	input  logic				rst_n
);

	logic [clock_pkg::FIELD_W-1:0]	hr;
	logic [clock_pkg::FIELD_W-1:0]	min;
	logic [clock_pkg::FIELD_W-1:0]	sec;
	logic [clock_pkg::FIELD_W-1:0]	al_hr;
	logic [clock_pkg::FIELD_W-1:0]	al_min;
	logic [clock_pkg::FIELD_W-1:0]	al_sec;
	logic				count_en;
	logic				time_match;

	function automatic logic [clock_pkg::FIELD_W-1:0] wrap_inc(
		input logic [clock_pkg::FIELD_W-1:0] val,
		input logic [clock_pkg::FIELD_W-1:0] last
	);
		return (val == last) ? '0 : val + 1'b1;
	endfunction

	assign count_en = i_sec_tick && (i_mode != clock_pkg::MODE_SETUP);	// frozen in setup

	// --------------------------------------------------
	// time of day
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hr  <= '0;
			min <= '0;
			sec <= '0;
		end else if (count_en) begin
			sec <= wrap_inc(sec, clock_pkg::SEC_MAX);
			if (sec == clock_pkg::SEC_MAX) begin
				min <= wrap_inc(min, clock_pkg::MIN_MAX);
				if (min == clock_pkg::MIN_MAX)
					hr <= wrap_inc(hr, clock_pkg::HR_MAX);
			end
		end else if (i_inc_time) begin
			case (i_pos)	// no carry when setting
				clock_pkg::POS_SEC:	sec <= wrap_inc(sec, clock_pkg::SEC_MAX);
				clock_pkg::POS_MIN:	min <= wrap_inc(min, clock_pkg::MIN_MAX);
				default:		hr  <= wrap_inc(hr, clock_pkg::HR_MAX);
			endcase
		end
	end

	// alarm time
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			al_hr  <= '0;
			al_min <= '0;
			al_sec <= '0;
		end else if (i_inc_alarm) begin
			case (i_pos)
				clock_pkg::POS_SEC:	al_sec <= wrap_inc(al_sec, clock_pkg::SEC_MAX);
				clock_pkg::POS_MIN:	al_min <= wrap_inc(al_min, clock_pkg::MIN_MAX);
				default:		al_hr  <= wrap_inc(al_hr, clock_pkg::HR_MAX);
			endcase
		end
	end

	assign time_match = ({hr, min, sec} == {al_hr, al_min, al_sec});

	// latches on match, dropped by the enable
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_alarm <= 1'b0;
		else
			o_alarm <= i_alarm_en && (time_match || o_alarm);
	end

	assign o_hr_show  = (i_mode == clock_pkg::MODE_ALARM) ? al_hr : hr;
	assign o_min_show = (i_mode == clock_pkg::MODE_ALARM) ? al_min : min;
	assign o_sec_show = (i_mode == clock_pkg::MODE_ALARM) ? al_sec : sec;

	a_field_limits: assert property (@(posedge clk) disable iff (!rst_n)
		sec <= clock_pkg::SEC_MAX && min <= clock_pkg::MIN_MAX && hr <= clock_pkg::HR_MAX &&
		al_sec <= clock_pkg::SEC_MAX && al_min <= clock_pkg::MIN_MAX &&
		al_hr <= clock_pkg::HR_MAX);

endmodule

`default_nettype wire
